// ==== bench/rv_bus_model.sv ====
`timescale 1ns/100ps

module rv_bus_model #(
  parameter logic [29:0] ERR_WORD = 30'h180
) (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic [29:0] adr_i,
  input  logic [3:0]  sel_i,
  input  logic        we_i,
  input  logic [31:0] dat_i,
  input  logic        stb_i,
  output logic [31:0] dat_o,
  output logic        ack_o,
  output logic        err_o
);

  logic [31:0] mem [0:1023];
  logic [31:0] log_adr [$];
  logic [31:0] log_dat [$];
  // negative picks random waits, otherwise a fixed count
  int          wait_mode;
  int          wait_cnt;
  logic        active;
  logic [15:0] lfsr;

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic respond();
    logic [9:0] a;
    a = adr_i[9:0];
    if (adr_i == ERR_WORD) begin
      err_o = 1'b1;
    end else begin
      ack_o = 1'b1;
      if (we_i) begin
        for (int b = 0; b < 4; b++) begin
          if (sel_i[b]) begin
            mem[a][8*b +: 8] = dat_i[8*b +: 8];
          end
        end
        log_adr.push_back({adr_i, 2'b00});
        log_dat.push_back(mem[a]);
      end else begin
        dat_o = mem[a];
      end
    end
  endtask

  initial begin
    dat_o     = '0;
    ack_o     = 1'b0;
    err_o     = 1'b0;
    active    = 1'b0;
    wait_cnt  = 0;
    wait_mode = -1;
    lfsr      = 16'd46654;
  end

  // responses change a little after the edge, one request at a time
  always @(posedge clk_i) begin
    #1;
    if (reset_i || ack_o || err_o) begin
      ack_o  = 1'b0;
      err_o  = 1'b0;
      active = 1'b0;
    end else if (stb_i) begin
      if (!active) begin
        active = 1'b1;
        if (wait_mode < 0) begin
          lfsr     = lfsr_step(lfsr);
          wait_cnt = int'(lfsr[0]);
          lfsr     = lfsr_step(lfsr);
          wait_cnt = wait_cnt + 2 * int'(lfsr[0]);
        end else begin
          wait_cnt = wait_mode;
        end
      end
      if (wait_cnt == 0) begin
        respond();
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

endmodule

// ==== bench/rv_core_tb.sv ====
`timescale 1ns/100ps

module rv_core_tb;

  localparam int          CLK_PERIOD     = 100;
  localparam int          RESET_CYCLES   = 16;
  localparam int          TIMEOUT_CYCLES = 8 * 400;
  localparam logic [31:0] RES_BASE       = 32'h400;
  localparam logic [31:0] DATA_ADR       = 32'h500;
  localparam logic [31:0] ERR_ADR        = 32'h600;
  localparam logic [31:0] DONE_ADR       = 32'h7F0;
  localparam logic [6:0]  OP_IMM         = 7'b0010011;
  localparam logic [6:0]  OP_LOAD        = 7'b0000011;
  localparam logic [6:0]  OP_LUI         = 7'b0110111;
  localparam logic [6:0]  OP_AUIPC       = 7'b0010111;
  localparam logic [6:0]  OP_JALR        = 7'b1100111;

  logic        clk_i;
  logic        reset_i;
  logic [31:0] dat_to_core;
  logic [31:0] dat_from_core;
  logic        ack;
  logic        err;
  logic [29:0] adr;
  logic [3:0]  sel;
  logic        we;
  logic        stb_o;
  logic        fault_o;
  logic [31:0] prog [$];
  logic [31:0] exp_q [$];
  logic [31:0] saved_adr [$];
  logic [31:0] saved_dat [$];
  int          cycles;

  rv_core UUT (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .dat_i   (dat_to_core),
    .ack_i   (ack),
    .err_i   (err),
    .adr_o   (adr),
    .sel_o   (sel),
    .we_o    (we),
    .dat_o   (dat_from_core),
    .stb_o   (stb_o),
    .fault_o (fault_o)
  );

  rv_bus_model #(.ERR_WORD(ERR_ADR[31:2])) mem_model (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .adr_i   (adr),
    .sel_i   (sel),
    .we_i    (we),
    .dat_i   (dat_from_core),
    .stb_i   (stb_o),
    .dat_o   (dat_to_core),
    .ack_o   (ack),
    .err_o   (err)
  );

  initial clk_i = 1'b0;
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: the core did not finish its programs in %0d cycles", TIMEOUT_CYCLES);
      $display("FAIL: see errors above");
      $fatal(1, "run stopped by timeout");
    end
  end

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("FAIL: see errors above");
      $fatal(1, "stopping at first error");
    end
  endtask

  // instruction encoders
  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [31:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] b_type(input logic [31:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
    return {imm, rd, op};
  endfunction

  function automatic logic [31:0] j_type(input logic [31:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] pc();
    return prog.size() * 4;
  endfunction

  function automatic bit store_seen(input logic [31:0] adr_b);
    foreach (mem_model.log_adr[i]) begin
      if (mem_model.log_adr[i] == adr_b) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  task automatic emit(input logic [31:0] word);
    prog.push_back(word);
  endtask

  // stores rs to the next result slot
  task automatic record(input logic [4:0] rs, input logic [31:0] expected);
    emit(s_type(RES_BASE + 4 * exp_q.size(), rs, 5'd0, 3'd2));
    exp_q.push_back(expected);
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] upper;
    upper = (v + 32'h800) >> 12;
    emit(u_type(upper[19:0], rd, OP_LUI));
    emit(i_type(v, rd, 3'd0, rd, OP_IMM));
  endtask

  task automatic new_program();
    prog.delete();
    exp_q.delete();
  endtask

  // done marker, then spin in place
  task automatic finish_program();
    emit(s_type(DONE_ADR, 5'd0, 5'd0, 3'd2));
    emit(j_type(32'd0, 5'd0));
  endtask

  task automatic load_memory();
    for (int i = 0; i < 1024; i++) begin
      mem_model.mem[i] = 32'hC0DE_0000 | i;
    end
    foreach (prog[i]) begin
      mem_model.mem[i] = prog[i];
    end
  endtask

  task automatic start_program();
    mem_model.log_adr.delete();
    mem_model.log_dat.delete();
    @(posedge clk_i);
    #1 reset_i = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1 reset_i = 1'b0;
  endtask

  task automatic run_program();
    start_program();
    while (!store_seen(DONE_ADR)) begin
      @(posedge clk_i);
    end
  endtask

  task automatic check_results(input string name);
    foreach (exp_q[k]) begin
      check($sformatf("%s %0d", name, k), exp_q[k], mem_model.mem[(RES_BASE >> 2) + k]);
    end
  endtask

  task automatic build_alu_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] pc_u;
    a = 32'h8765_4321;
    b = 32'd5;
    c = 32'hFFFF_FFF9;
    new_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    load_const(5'd3, c);
    emit(r_type(7'h00, 2, 1, 0, 5));
    record(5, a + b);
    emit(r_type(7'h20, 2, 1, 0, 5));
    record(5, a - b);
    emit(r_type(7'h00, 2, 1, 1, 5));
    record(5, a << b[4:0]);
    emit(r_type(7'h00, 2, 1, 2, 5));
    record(5, ($signed(a) < $signed(b)) ? 1 : 0);
    emit(r_type(7'h00, 2, 1, 3, 5));
    record(5, (a < b) ? 1 : 0);
    emit(r_type(7'h00, 1, 3, 2, 5));
    record(5, ($signed(c) < $signed(a)) ? 1 : 0);
    emit(r_type(7'h00, 2, 1, 4, 5));
    record(5, a ^ b);
    emit(r_type(7'h00, 2, 1, 5, 5));
    record(5, a >> b[4:0]);
    emit(r_type(7'h20, 2, 1, 5, 5));
    record(5, $signed(a) >>> b[4:0]);
    emit(r_type(7'h00, 2, 1, 6, 5));
    record(5, a | b);
    emit(r_type(7'h00, 2, 1, 7, 5));
    record(5, a & b);
    emit(i_type(-100, 1, 0, 5, OP_IMM));
    record(5, a - 100);
    emit(i_type(-6, 3, 2, 5, OP_IMM));
    record(5, 32'd1);
    emit(i_type(-1, 2, 3, 5, OP_IMM));
    record(5, 32'd1);
    emit(i_type(32'h7FF, 1, 4, 5, OP_IMM));
    record(5, a ^ 32'h7FF);
    emit(i_type(32'h0F0, 1, 6, 5, OP_IMM));
    record(5, a | 32'h0F0);
    // 0xF0F sign-extends to a negative mask
    emit(i_type(32'hF0F, 1, 7, 5, OP_IMM));
    record(5, a & 32'hFFFF_FF0F);
    emit(i_type(32'd4, 1, 1, 5, OP_IMM));
    record(5, a << 4);
    emit(i_type(32'd8, 1, 5, 5, OP_IMM));
    record(5, a >> 8);
    emit(i_type(32'h408, 1, 5, 5, OP_IMM));
    record(5, $signed(a) >>> 8);
    emit(u_type(20'hABCDE, 5, OP_LUI));
    record(5, 32'hABCD_E000);
    pc_u = pc();
    emit(u_type(20'h12345, 5, OP_AUIPC));
    record(5, 32'h1234_5000 + pc_u);
    finish_program();
  endtask

  task automatic test_alu();
    build_alu_program();
    load_memory();
    run_program();
    check_results("alu");
  endtask

  task automatic load_case(input logic [31:0] off, input logic [2:0] f3,
                           input logic [31:0] expected);
    emit(i_type(DATA_ADR + off, 0, f3, 5, OP_LOAD));
    record(5, expected);
  endtask

  task automatic test_loads_stores();
    logic [31:0] w;
    w = 32'h80F1_7F82;
    new_program();
    load_case(0, 3'd0, {{24{w[7]}}, w[7:0]});
    load_case(1, 3'd4, {24'h0, w[15:8]});
    load_case(2, 3'd0, {{24{w[23]}}, w[23:16]});
    load_case(3, 3'd4, {24'h0, w[31:24]});
    load_case(3, 3'd0, {{24{w[31]}}, w[31:24]});
    load_case(0, 3'd1, {{16{w[15]}}, w[15:0]});
    load_case(2, 3'd1, {{16{w[31]}}, w[31:16]});
    load_case(2, 3'd5, {16'h0, w[31:16]});
    load_case(0, 3'd2, w);
    load_const(5'd6, 32'hCAFE_BEEF);
    emit(s_type(DATA_ADR + 5, 6, 0, 3'd0));
    emit(s_type(DATA_ADR + 6, 6, 0, 3'd1));
    emit(s_type(DATA_ADR + 11, 6, 0, 3'd0));
    emit(s_type(DATA_ADR + 8, 6, 0, 3'd1));
    finish_program();
    load_memory();
    mem_model.mem[DATA_ADR >> 2]       = w;
    mem_model.mem[(DATA_ADR >> 2) + 1] = 32'h1122_3344;
    mem_model.mem[(DATA_ADR >> 2) + 2] = 32'h5566_7788;
    run_program();
    check_results("load");
    check("store byte then half", {16'hBEEF, 8'hEF, 8'h44},
          mem_model.mem[(DATA_ADR >> 2) + 1]);
    check("store top byte then low half", {8'hEF, 8'h66, 16'hBEEF},
          mem_model.mem[(DATA_ADR >> 2) + 2]);
  endtask

  // marker 2 when taken, 1 when the jal skips the taken path
  task automatic branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                             input logic [4:0] rs2, input bit taken);
    emit(i_type(1, 0, 0, 5, OP_IMM));
    emit(b_type(8, rs2, rs1, f3));
    emit(j_type(8, 0));
    emit(i_type(2, 0, 0, 5, OP_IMM));
    record(5, taken ? 32'd2 : 32'd1);
  endtask

  task automatic test_branches();
    new_program();
    emit(i_type(-2, 0, 0, 1, OP_IMM));
    emit(i_type(3, 0, 0, 2, OP_IMM));
    branch_case(3'd0, 1, 1, 1);
    branch_case(3'd0, 1, 2, 0);
    branch_case(3'd1, 1, 2, 1);
    branch_case(3'd1, 1, 1, 0);
    branch_case(3'd4, 1, 2, 1);
    branch_case(3'd4, 2, 1, 0);
    branch_case(3'd5, 2, 1, 1);
    branch_case(3'd5, 1, 2, 0);
    branch_case(3'd6, 2, 1, 1);
    branch_case(3'd6, 1, 2, 0);
    branch_case(3'd7, 1, 2, 1);
    branch_case(3'd7, 2, 1, 0);
    finish_program();
    load_memory();
    run_program();
    check_results("branch");
  endtask

  task automatic test_jumps();
    logic [31:0] pc_j;
    logic [31:0] pc_a;
    new_program();
    emit(i_type(1, 0, 0, 5, OP_IMM));
    pc_j = pc();
    emit(j_type(8, 1));
    emit(i_type(9, 0, 0, 5, OP_IMM));
    record(1, pc_j + 4);
    record(5, 32'd1);
    pc_a = pc();
    // odd target so jalr must clear bit 0
    emit(i_type(pc_a + 12, 0, 0, 7, OP_IMM));
    emit(i_type(1, 7, 0, 2, OP_JALR));
    emit(i_type(9, 0, 0, 5, OP_IMM));
    record(2, pc_a + 8);
    record(5, 32'd1);
    finish_program();
    load_memory();
    run_program();
    check_results("jump");
  endtask

  task automatic test_wait_states();
    build_alu_program();
    load_memory();
    mem_model.wait_mode = 0;
    run_program();
    saved_adr = mem_model.log_adr;
    saved_dat = mem_model.log_dat;
    load_memory();
    mem_model.wait_mode = -1;
    run_program();
    check("wait states log size", saved_adr.size(), mem_model.log_adr.size());
    foreach (saved_adr[i]) begin
      check($sformatf("wait states adr %0d", i), saved_adr[i], mem_model.log_adr[i]);
      check($sformatf("wait states dat %0d", i), saved_dat[i], mem_model.log_dat[i]);
    end
    check_results("wait states");
  endtask

  task automatic test_bus_error();
    new_program();
    emit(i_type(1, 0, 0, 5, OP_IMM));
    record(5, 32'd1);
    emit(i_type(ERR_ADR, 0, 3'd2, 6, OP_LOAD));
    record(5, 32'd1);
    finish_program();
    load_memory();
    start_program();
    while (!fault_o) begin
      @(posedge clk_i);
    end
    repeat (20) begin
      @(posedge clk_i);
      check("bus error strobe", 32'd0, stb_o);
      check("bus error fault", 32'd1, fault_o);
    end
    check("bus error writes", 32'd1, mem_model.log_adr.size());
    check("bus error done store", 32'd0, store_seen(DONE_ADR));
  endtask

  initial begin
    reset_i = 1'b1;
    cycles  = 0;
    test_alu();
    test_loads_stores();
    test_branches();
    test_jumps();
    test_wait_states();
    test_bus_error();
    $display("PASS: all tests");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the core testbench, exit status is the simulation result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal \
       --top-module rv_core_tb -f verilog.f -o rv_core_tb \
  && ./obj_dir/rv_core_tb \
  || { echo "simulation did not pass"; exit 1; }

// ==== verilog.f ====
verilog/rv_core_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_alu.sv
verilog/rv_lsu.sv
verilog/rv_core.sv
bench/rv_bus_model.sv
bench/rv_core_tb.sv

// ==== verilog/rv_alu.sv ====
`timescale 1ns/100ps

module rv_alu (
  input  rv_core_pkg::alu_op_e          op_i,
  input  logic [rv_core_pkg::XLEN-1:0]  a_i,
  input  logic [rv_core_pkg::XLEN-1:0]  b_i,
  input  logic [2:0]                    cond_i,
  output logic [rv_core_pkg::XLEN-1:0]  result_o,
  output logic                          take_branch_o
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt;
  logic       ltu;

  assign shamt = b_i[4:0];
  assign eq    = (a_i == b_i);
  assign lt    = ($signed(a_i) < $signed(b_i));
  assign ltu   = (a_i < b_i);

  always_comb begin
    case (op_i)
      rv_core_pkg::ALU_ADD:    result_o = a_i + b_i;
      rv_core_pkg::ALU_SUB:    result_o = a_i - b_i;
      rv_core_pkg::ALU_SLL:    result_o = a_i << shamt;
      rv_core_pkg::ALU_SLT:    result_o = {{(rv_core_pkg::XLEN-1){1'b0}}, lt};
      rv_core_pkg::ALU_SLTU:   result_o = {{(rv_core_pkg::XLEN-1){1'b0}}, ltu};
      rv_core_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      rv_core_pkg::ALU_SRL:    result_o = a_i >> shamt;
      rv_core_pkg::ALU_SRA:    result_o = $signed(a_i) >>> shamt;
      rv_core_pkg::ALU_OR:     result_o = a_i | b_i;
      rv_core_pkg::ALU_AND:    result_o = a_i & b_i;
      rv_core_pkg::ALU_PASS_B: result_o = b_i;
      default:                 result_o = a_i + b_i;
    endcase
  end

  // branch funct3 encodings, 010 and 011 are unused
  always_comb begin
    case (cond_i)
      3'b000:  take_branch_o = eq;
      3'b001:  take_branch_o = !eq;
      3'b100:  take_branch_o = lt;
      3'b101:  take_branch_o = !lt;
      3'b110:  take_branch_o = ltu;
      3'b111:  take_branch_o = !ltu;
      default: take_branch_o = 1'b0;
    endcase
  end

endmodule

// ==== verilog/rv_core.sv ====
`timescale 1ns/100ps

module rv_core (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic [rv_core_pkg::XLEN-1:0]   dat_i,
  input  logic                           ack_i,
  input  logic                           err_i,
  output logic [rv_core_pkg::XLEN-3:0]   adr_o,
  output logic [3:0]                     sel_o,
  output logic                           we_o,
  output logic [rv_core_pkg::XLEN-1:0]   dat_o,
  output logic                           stb_o,
  output logic                           fault_o
);

  typedef enum logic [2:0] {
    ST_FETCH,
    ST_DECODE,
    ST_EXEC,
    ST_MEM,
    ST_WB,
    ST_HALT
  } state_e;

  state_e                        state_q;
  logic [rv_core_pkg::XLEN-1:0]  pc_q;
  rv_core_pkg::decoded_instr_t   dec;
  rv_core_pkg::decoded_instr_t   dec_q;
  logic [rv_core_pkg::XLEN-1:0]  rs1_q;
  logic [rv_core_pkg::XLEN-1:0]  rs2_q;
  logic [rv_core_pkg::XLEN-1:0]  alu_q;
  logic                          take_q;

  rv_core_pkg::bus_req_t         fetch_req;
  rv_core_pkg::bus_req_t         lsu_req;
  rv_core_pkg::bus_req_t         bus;
  logic [rv_core_pkg::XLEN-1:0]  instr;
  logic                          fetch_done;
  logic [rv_core_pkg::XLEN-1:0]  rs1;
  logic [rv_core_pkg::XLEN-1:0]  rs2;
  logic [rv_core_pkg::XLEN-1:0]  alu_b;
  logic [rv_core_pkg::XLEN-1:0]  alu_result;
  logic                          take_branch;
  logic [rv_core_pkg::XLEN-1:0]  load_data;
  logic                          lsu_done;
  logic                          is_mem;
  logic [rv_core_pkg::XLEN-1:0]  pc_plus4;
  logic [rv_core_pkg::XLEN-1:0]  pc_imm;
  logic [rv_core_pkg::XLEN-1:0]  wb_data;
  logic [rv_core_pkg::XLEN-1:0]  pc_next;

  rv_fetch u_fetch (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .start_i (state_q == ST_FETCH && !fetch_req.stb),
    .pc_i    (pc_q),
    .ack_i   (ack_i),
    .err_i   (err_i),
    .dat_i   (dat_i),
    .req_o   (fetch_req),
    .instr_o (instr),
    .done_o  (fetch_done)
  );

  rv_decode u_decode (
    .instr_i (instr),
    .dec_o   (dec)
  );

  // read during DECODE, written at the WB edge
  rv_regfile u_regfile (
    .clk_i      (clk_i),
    .rs1_addr_i (dec.rs1),
    .rs2_addr_i (dec.rs2),
    .rd_addr_i  (dec_q.rd),
    .we_i       (state_q == ST_WB && dec_q.reg_write),
    .rd_data_i  (wb_data),
    .rs1_o      (rs1),
    .rs2_o      (rs2)
  );

  assign alu_b = dec_q.use_imm ? dec_q.imm : rs2_q;

  rv_alu u_alu (
    .op_i          (dec_q.alu_op),
    .a_i           (rs1_q),
    .b_i           (alu_b),
    .cond_i        (dec_q.funct3),
    .result_o      (alu_result),
    .take_branch_o (take_branch)
  );

  rv_lsu u_lsu (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .start_i    (state_q == ST_MEM && !lsu_req.stb),
    .addr_i     (alu_q),
    .wdata_i    (rs2_q),
    .write_i    (dec_q.cls == rv_core_pkg::CLS_STORE),
    .size_i     (dec_q.size),
    .unsigned_i (dec_q.load_unsigned),
    .ack_i      (ack_i),
    .err_i      (err_i),
    .dat_i      (dat_i),
    .req_o      (lsu_req),
    .rdata_o    (load_data),
    .done_o     (lsu_done)
  );

  assign is_mem   = (dec_q.cls == rv_core_pkg::CLS_LOAD) ||
                    (dec_q.cls == rv_core_pkg::CLS_STORE);
  assign pc_plus4 = pc_q + 32'd4;
  assign pc_imm   = pc_q + dec_q.imm;

  always_comb begin
    case (dec_q.cls)
      rv_core_pkg::CLS_LOAD:  wb_data = load_data;
      rv_core_pkg::CLS_JAL,
      rv_core_pkg::CLS_JALR:  wb_data = pc_plus4;
      rv_core_pkg::CLS_AUIPC: wb_data = pc_imm;
      default:                wb_data = alu_q;
    endcase
  end

  // jalr target is rs1+imm from the alu with bit 0 cleared
  always_comb begin
    if (dec_q.cls == rv_core_pkg::CLS_JAL || take_q) begin
      pc_next = pc_imm;
    end else if (dec_q.cls == rv_core_pkg::CLS_JALR) begin
      pc_next = {alu_q[rv_core_pkg::XLEN-1:1], 1'b0};
    end else begin
      pc_next = pc_plus4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= ST_FETCH;
      pc_q    <= rv_core_pkg::RESET_PC;
    end else begin
      case (state_q)
        ST_FETCH: begin
          if (fetch_req.stb && err_i) begin
            state_q <= ST_HALT;
          end else if (fetch_done) begin
            state_q <= ST_DECODE;
          end
        end
        ST_DECODE: state_q <= ST_EXEC;
        ST_EXEC:   state_q <= is_mem ? ST_MEM : ST_WB;
        ST_MEM: begin
          if (lsu_req.stb && err_i) begin
            state_q <= ST_HALT;
          end else if (lsu_done) begin
            state_q <= ST_WB;
          end
        end
        ST_WB: begin
          state_q <= ST_FETCH;
          pc_q    <= pc_next;
        end
        default: state_q <= ST_HALT;
      endcase
    end
  end

  // operand and result latches along the instruction
  always_ff @(posedge clk_i) begin
    if (state_q == ST_DECODE) begin
      dec_q <= dec;
      rs1_q <= rs1;
      rs2_q <= rs2;
    end
    if (state_q == ST_EXEC) begin
      alu_q  <= alu_result;
      take_q <= take_branch && dec_q.cls == rv_core_pkg::CLS_BRANCH;
    end
  end

  // bus owner follows the state
  always_comb begin
    bus = '0;
    if (state_q == ST_FETCH) begin
      bus = fetch_req;
    end else if (state_q == ST_MEM) begin
      bus = lsu_req;
    end
  end

  assign adr_o   = bus.adr;
  assign sel_o   = bus.sel;
  assign we_o    = bus.we;
  assign dat_o   = bus.dat;
  assign stb_o   = bus.stb;
  assign fault_o = (state_q == ST_HALT);

  // neither unit may keep its strobe up once the core has halted
  assert property (@(posedge clk_i) disable iff (reset_i)
    state_q == ST_HALT |-> !fetch_req.stb && !lsu_req.stb)
    else $error("bus strobe raised after a fault");

  // a request holds until its response
  assert property (@(posedge clk_i) disable iff (reset_i)
    stb_o && !ack_i && !err_i |=> stb_o && $stable(adr_o))
    else $error("bus request changed before its response");

endmodule

// ==== verilog/rv_core_pkg.sv ====
package rv_core_pkg;

  localparam int XLEN = 32;
  localparam int REG_BITS = 5;
  localparam logic [XLEN-1:0] RESET_PC = '0;

  // pass_b carries the immediate straight through for lui
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [2:0] {
    CLS_ALU,
    CLS_LOAD,
    CLS_STORE,
    CLS_BRANCH,
    CLS_JAL,
    CLS_JALR,
    CLS_AUIPC,
    CLS_ILLEGAL
  } instr_class_e;

  typedef enum logic [1:0] {
    SIZE_BYTE,
    SIZE_HALF,
    SIZE_WORD
  } mem_size_e;

  typedef struct packed {
    instr_class_e        cls;
    alu_op_e             alu_op;
    logic [REG_BITS-1:0] rs1;
    logic [REG_BITS-1:0] rs2;
    logic [REG_BITS-1:0] rd;
    logic [XLEN-1:0]     imm;
    logic                use_imm;
    logic [2:0]          funct3;
    mem_size_e           size;
    logic                load_unsigned;
    logic                reg_write;
  } decoded_instr_t;

  // one word-bus request, adr is a word address
  typedef struct packed {
    logic [XLEN-3:0] adr;
    logic [3:0]      sel;
    logic            we;
    logic [XLEN-1:0] dat;
    logic            stb;
  } bus_req_t;

endpackage

// ==== verilog/rv_decode.sv ====
`timescale 1ns/100ps

module rv_decode (
  input  logic [rv_core_pkg::XLEN-1:0] instr_i,
  output rv_core_pkg::decoded_instr_t  dec_o
);

  logic [rv_core_pkg::XLEN-1:0] imm_i;
  logic [rv_core_pkg::XLEN-1:0] imm_s;
  logic [rv_core_pkg::XLEN-1:0] imm_b;
  logic [rv_core_pkg::XLEN-1:0] imm_u;
  logic [rv_core_pkg::XLEN-1:0] imm_j;

  // alt selects sub or sra from bit 30
  function automatic rv_core_pkg::alu_op_e alu_from_funct3(input logic [2:0] f3,
                                                           input logic alt);
    case (f3)
      3'b000:  return alt ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
      3'b001:  return rv_core_pkg::ALU_SLL;
      3'b010:  return rv_core_pkg::ALU_SLT;
      3'b011:  return rv_core_pkg::ALU_SLTU;
      3'b100:  return rv_core_pkg::ALU_XOR;
      3'b101:  return alt ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      3'b110:  return rv_core_pkg::ALU_OR;
      default: return rv_core_pkg::ALU_AND;
    endcase
  endfunction

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb begin
    dec_o               = '0;
    dec_o.cls           = rv_core_pkg::CLS_ILLEGAL;
    dec_o.alu_op        = rv_core_pkg::ALU_ADD;
    dec_o.rs1           = instr_i[19:15];
    dec_o.rs2           = instr_i[24:20];
    dec_o.rd            = instr_i[11:7];
    dec_o.funct3        = instr_i[14:12];
    dec_o.load_unsigned = instr_i[14];
    case (instr_i[13:12])
      2'b00:   dec_o.size = rv_core_pkg::SIZE_BYTE;
      2'b01:   dec_o.size = rv_core_pkg::SIZE_HALF;
      default: dec_o.size = rv_core_pkg::SIZE_WORD;
    endcase

    case (instr_i[6:0])
      7'b0110111: begin
        // lui
        dec_o.cls       = rv_core_pkg::CLS_ALU;
        dec_o.alu_op    = rv_core_pkg::ALU_PASS_B;
        dec_o.imm       = imm_u;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      7'b0010111: begin
        dec_o.cls       = rv_core_pkg::CLS_AUIPC;
        dec_o.imm       = imm_u;
        dec_o.reg_write = 1'b1;
      end
      7'b1101111: begin
        dec_o.cls       = rv_core_pkg::CLS_JAL;
        dec_o.imm       = imm_j;
        dec_o.reg_write = 1'b1;
      end
      7'b1100111: begin
        dec_o.cls       = rv_core_pkg::CLS_JALR;
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      7'b1100011: begin
        dec_o.cls    = rv_core_pkg::CLS_BRANCH;
        dec_o.alu_op = rv_core_pkg::ALU_SUB;
        dec_o.imm    = imm_b;
      end
      7'b0000011: begin
        dec_o.cls       = rv_core_pkg::CLS_LOAD;
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      7'b0100011: begin
        dec_o.cls     = rv_core_pkg::CLS_STORE;
        dec_o.imm     = imm_s;
        dec_o.use_imm = 1'b1;
      end
      7'b0010011: begin
        // only shifts use bit 30 in the immediate form
        dec_o.cls       = rv_core_pkg::CLS_ALU;
        dec_o.alu_op    = alu_from_funct3(instr_i[14:12],
                                          instr_i[30] && instr_i[13:12] == 2'b01);
        dec_o.imm       = imm_i;
        dec_o.use_imm   = 1'b1;
        dec_o.reg_write = 1'b1;
      end
      7'b0110011: begin
        dec_o.cls       = rv_core_pkg::CLS_ALU;
        dec_o.alu_op    = alu_from_funct3(instr_i[14:12], instr_i[30]);
        dec_o.reg_write = 1'b1;
      end
      default: begin
        dec_o.reg_write = 1'b0;
      end
    endcase

    // x0 is never written
    if (dec_o.rd == '0) begin
      dec_o.reg_write = 1'b0;
    end
  end

endmodule

// ==== verilog/rv_fetch.sv ====
`timescale 1ns/100ps

module rv_fetch (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           start_i,
  input  logic [rv_core_pkg::XLEN-1:0]   pc_i,
  input  logic                           ack_i,
  input  logic                           err_i,
  input  logic [rv_core_pkg::XLEN-1:0]   dat_i,
  output rv_core_pkg::bus_req_t          req_o,
  output logic [rv_core_pkg::XLEN-1:0]   instr_o,
  output logic                           done_o
);

  logic                           stb_q;
  logic [rv_core_pkg::XLEN-3:0]   adr_q;
  logic [rv_core_pkg::XLEN-1:0]   instr_q;

  // strobe stays up until ack or err
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stb_q <= 1'b0;
    end else if (start_i) begin
      stb_q <= 1'b1;
    end else if (ack_i || err_i) begin
      stb_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_q <= pc_i[rv_core_pkg::XLEN-1:2];
    end
    if (stb_q && ack_i) begin
      instr_q <= dat_i;
    end
  end

  // instruction reads are always full words
  assign req_o.adr = adr_q;
  assign req_o.sel = 4'b1111;
  assign req_o.we  = 1'b0;
  assign req_o.dat = '0;
  assign req_o.stb = stb_q;

  assign instr_o = instr_q;
  assign done_o  = stb_q & ack_i;

  // the sequencer must wait for the response before the next fetch
  assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !stb_q)
    else $error("fetch started while a request is pending");

endmodule

// ==== verilog/rv_lsu.sv ====
`timescale 1ns/100ps

module rv_lsu (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           start_i,
  input  logic [rv_core_pkg::XLEN-1:0]   addr_i,
  input  logic [rv_core_pkg::XLEN-1:0]   wdata_i,
  input  logic                           write_i,
  input  rv_core_pkg::mem_size_e         size_i,
  input  logic                           unsigned_i,
  input  logic                           ack_i,
  input  logic                           err_i,
  input  logic [rv_core_pkg::XLEN-1:0]   dat_i,
  output rv_core_pkg::bus_req_t          req_o,
  output logic [rv_core_pkg::XLEN-1:0]   rdata_o,
  output logic                           done_o
);

  logic                           stb_q;
  logic [rv_core_pkg::XLEN-3:0]   adr_q;
  logic [3:0]                     sel_q;
  logic                           we_q;
  logic [rv_core_pkg::XLEN-1:0]   dat_q;
  logic [rv_core_pkg::XLEN-1:0]   rdata_q;
  logic [3:0]                     sel;
  logic [rv_core_pkg::XLEN-1:0]   store_dat;
  logic [rv_core_pkg::XLEN-1:0]   lane;
  logic [rv_core_pkg::XLEN-1:0]   load_ext;

  // lane select and replicated store data
  always_comb begin
    case (size_i)
      rv_core_pkg::SIZE_BYTE: begin
        sel       = 4'b0001 << addr_i[1:0];
        store_dat = {4{wdata_i[7:0]}};
      end
      rv_core_pkg::SIZE_HALF: begin
        sel       = addr_i[1] ? 4'b1100 : 4'b0011;
        store_dat = {2{wdata_i[15:0]}};
      end
      default: begin
        sel       = 4'b1111;
        store_dat = wdata_i;
      end
    endcase
  end

  // move the addressed lane down to bit 0, then extend
  assign lane = dat_i >> {addr_i[1:0], 3'b000};

  always_comb begin
    case (size_i)
      rv_core_pkg::SIZE_BYTE:
        load_ext = {{24{lane[7] & !unsigned_i}}, lane[7:0]};
      rv_core_pkg::SIZE_HALF:
        load_ext = {{16{lane[15] & !unsigned_i}}, lane[15:0]};
      default:
        load_ext = lane;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      stb_q <= 1'b0;
    end else if (start_i) begin
      stb_q <= 1'b1;
    end else if (ack_i || err_i) begin
      stb_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (start_i) begin
      adr_q <= addr_i[rv_core_pkg::XLEN-1:2];
      sel_q <= sel;
      we_q  <= write_i;
      dat_q <= store_dat;
    end
    if (stb_q && ack_i) begin
      rdata_q <= load_ext;
    end
  end

  assign req_o.adr = adr_q;
  assign req_o.sel = sel_q;
  assign req_o.we  = we_q;
  assign req_o.dat = dat_q;
  assign req_o.stb = stb_q;

  assign rdata_o = rdata_q;
  assign done_o  = stb_q & ack_i;

  // no misaligned traps, so the decoded program must keep halves even
  assert property (@(posedge clk_i) disable iff (reset_i)
    start_i && size_i == rv_core_pkg::SIZE_HALF |-> !addr_i[0])
    else $error("half access to odd address %h", addr_i);

endmodule

// ==== verilog/rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic                              clk_i,
  input  logic [rv_core_pkg::REG_BITS-1:0]  rs1_addr_i,
  input  logic [rv_core_pkg::REG_BITS-1:0]  rs2_addr_i,
  input  logic [rv_core_pkg::REG_BITS-1:0]  rd_addr_i,
  input  logic                              we_i,
  input  logic [rv_core_pkg::XLEN-1:0]      rd_data_i,
  output logic [rv_core_pkg::XLEN-1:0]      rs1_o,
  output logic [rv_core_pkg::XLEN-1:0]      rs2_o
);

  // x1..x31 only, x0 is hardwired
  logic [rv_core_pkg::XLEN-1:0] regs [1:31];

  always_ff @(posedge clk_i) begin
    if (we_i && rd_addr_i != '0) begin
      regs[rd_addr_i] <= rd_data_i;
    end
  end

  assign rs1_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

endmodule
